/* hw/rv_dec_pkg.sv */
// RV32I decode definitions
// Opcodes, funct3 codes, operand and LSU encodings, instruction views
// and the control word handed to execute
`default_nettype none

package rv_dec_pkg;

  typedef logic [31:0] pc_t;
  typedef logic [31:0] rdata_t;
  typedef logic [31:0] instr_raw_t;
  typedef logic [4:0]  raddr_t;

  typedef enum logic [6:0] {
    RV_OP_IMM   = 7'b0010011,
    RV_LUI      = 7'b0110111,
    RV_AUIPC    = 7'b0010111,
    RV_OP       = 7'b0110011,
    RV_JAL      = 7'b1101111,
    RV_JALR     = 7'b1100111,
    RV_BRANCH   = 7'b1100011,
    RV_LOAD     = 7'b0000011,
    RV_STORE    = 7'b0100011,
    RV_MISC_MEM = 7'b0001111,
    RV_SYSTEM   = 7'b1110011
  } opcode_t;

  localparam logic [2:0] F3_ADD      = 3'b000;
  localparam logic [2:0] F3_SR       = 3'b101;
  localparam logic [2:0] F3_PRIV     = 3'b000;
  localparam logic [2:0] F3_SYS_RSVD = 3'b100;

  localparam logic [6:0] F7_MRET = 7'h18;
  localparam logic [6:0] F7_WFI  = 7'h08;

  typedef enum logic [2:0] {I_IMM, S_IMM, B_IMM, U_IMM, J_IMM, CSR_IMM} imm_fmt_t;

  typedef enum logic [1:0] {REG_RF, IMM, PC, ZERO} op_sel_t;

  typedef enum logic [1:0] {LSU_NONE, LSU_LOAD, LSU_STORE} lsu_t;

  typedef struct packed {
    logic [6:0] funct7;
    raddr_t     rs2;
    raddr_t     rs1;
    logic [2:0] funct3;
    raddr_t     rd;
    logic [6:0] opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm12;
    raddr_t      rs1;
    logic [2:0]  funct3;
    raddr_t      rd;
    logic [6:0]  opcode;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  // All zeros is a NOP
  typedef struct packed {
    raddr_t      rd_addr;
    raddr_t      rs1_addr;
    raddr_t      rs2_addr;
    logic [2:0]  funct3;
    logic        alt;
    op_sel_t     rs1_op;
    op_sel_t     rs2_op;
    rdata_t      imm;
    logic        we_rd;
    logic        jump;
    logic        branch;
    lsu_t        lsu;
    logic [2:0]  lsu_w;
    logic [2:0]  csr_op;
    logic [11:0] csr_addr;
    logic        csr_rs1_is_x0;
    logic        ecall;
    logic        ebreak;
    logic        mret;
    logic        wfi;
    pc_t         pc_dec;
  } id_ex_t;

  typedef struct packed {
    logic       active;
    pc_t        pc_addr;
    instr_raw_t mtval;
  } trap_t;

endpackage

`default_nettype wire

/* hw/imm_gen.sv */
// Immediate generator
// Builds the sign-extended RV32I immediate of the selected format
`timescale 1ns/1ps
`default_nettype none

module imm_gen
  import rv_dec_pkg::*;
(
  input  instr_u   instr_i,
  input  imm_fmt_t fmt_i,
  output rdata_t   imm_o
);

  always_comb begin
    case (fmt_i)
      I_IMM:   imm_o = {{20{instr_i.i.imm12[11]}}, instr_i.i.imm12};
      S_IMM:   imm_o = {{20{instr_i.i.imm12[11]}}, instr_i.i.imm12[11:5], instr_i.i.rd};
      B_IMM:   imm_o = {{20{instr_i.i.imm12[11]}}, instr_i.i.rd[0], instr_i.i.imm12[10:5],
                        instr_i.i.rd[4:1], 1'b0};
      U_IMM:   imm_o = {instr_i.i.imm12, instr_i.i.rs1, instr_i.i.funct3, 12'h000};
      // imm[19:12] sits in the rs1 and funct3 slots
      J_IMM:   imm_o = {{12{instr_i.i.imm12[11]}}, instr_i.i.rs1, instr_i.i.funct3,
                        instr_i.i.imm12[0], instr_i.i.imm12[10:1], 1'b0};
      CSR_IMM: imm_o = {27'h0, instr_i.i.rs1};
      default: imm_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/instr_decoder.sv */
// Instruction field decoder
// Turns an RV32I/Zicsr instruction word into the execute control word
// and flags encodings that are not supported
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
  import rv_dec_pkg::*;
(
  input  instr_u instr_i,
  output id_ex_t ctrl_o,
  output logic   illegal_o
);

  imm_fmt_t imm_fmt;
  rdata_t   imm;

  always_comb begin
    case (instr_i.r.opcode)
      RV_LUI, RV_AUIPC: imm_fmt = U_IMM;
      RV_JAL:           imm_fmt = J_IMM;
      RV_BRANCH:        imm_fmt = B_IMM;
      RV_STORE:         imm_fmt = S_IMM;
      RV_SYSTEM:        imm_fmt = CSR_IMM;
      default:          imm_fmt = I_IMM;
    endcase
  end

  imm_gen u_imm_gen (
    .instr_i (instr_i),
    .fmt_i   (imm_fmt),
    .imm_o   (imm)
  );

  always_comb begin
    ctrl_o          = '0;
    illegal_o       = 1'b0;
    ctrl_o.rd_addr  = instr_i.r.rd;
    ctrl_o.rs1_addr = instr_i.r.rs1;
    ctrl_o.rs2_addr = instr_i.r.rs2;

    case (instr_i.r.opcode)
      RV_OP_IMM: begin
        ctrl_o.funct3 = instr_i.r.funct3;
        ctrl_o.alt    = (instr_i.r.funct3 == F3_SR) ? instr_i.r.funct7[5] : 1'b0;
        ctrl_o.rs1_op = REG_RF;
        ctrl_o.rs2_op = IMM;
        ctrl_o.imm    = imm;
        ctrl_o.we_rd  = 1'b1;
      end
      RV_LUI, RV_AUIPC: begin
        ctrl_o.funct3 = F3_ADD;
        ctrl_o.rs1_op = (instr_i.r.opcode == RV_LUI) ? ZERO : PC;
        ctrl_o.rs2_op = IMM;
        ctrl_o.imm    = imm;
        ctrl_o.we_rd  = 1'b1;
      end
      RV_OP: begin
        ctrl_o.funct3 = instr_i.r.funct3;
        ctrl_o.alt    = instr_i.r.funct7[5];
        ctrl_o.rs1_op = REG_RF;
        ctrl_o.rs2_op = REG_RF;
        ctrl_o.we_rd  = 1'b1;
      end
      RV_JAL, RV_JALR: begin
        // Target address computed as base + offset in execute
        ctrl_o.jump   = 1'b1;
        ctrl_o.funct3 = F3_ADD;
        ctrl_o.rs1_op = (instr_i.r.opcode == RV_JAL) ? PC : REG_RF;
        ctrl_o.rs2_op = IMM;
        ctrl_o.imm    = imm;
        ctrl_o.we_rd  = 1'b1;
      end
      RV_BRANCH: begin
        ctrl_o.branch = 1'b1;
        ctrl_o.funct3 = instr_i.r.funct3;
        ctrl_o.rs1_op = REG_RF;
        ctrl_o.rs2_op = REG_RF;
        ctrl_o.imm    = imm;
      end
      RV_LOAD, RV_STORE: begin
        ctrl_o.lsu    = (instr_i.r.opcode == RV_LOAD) ? LSU_LOAD : LSU_STORE;
        ctrl_o.lsu_w  = instr_i.r.funct3;
        ctrl_o.funct3 = F3_ADD;
        ctrl_o.rs1_op = REG_RF;
        ctrl_o.rs2_op = IMM;
        ctrl_o.imm    = imm;
        ctrl_o.we_rd  = (instr_i.r.opcode == RV_LOAD);
      end
      RV_MISC_MEM: begin
        ctrl_o.funct3 = F3_ADD;
        ctrl_o.rs1_op = ZERO;
        ctrl_o.rs2_op = ZERO;
      end
      RV_SYSTEM: begin
        ctrl_o.funct3 = F3_ADD;
        ctrl_o.rs1_op = ZERO;
        ctrl_o.rs2_op = ZERO;
        ctrl_o.imm    = imm;
        if ((instr_i.r.funct3 != F3_PRIV) && (instr_i.r.funct3 != F3_SYS_RSVD)) begin
          // funct3[2] picks the zimm form
          ctrl_o.rs1_op        = instr_i.r.funct3[2] ? IMM : REG_RF;
          ctrl_o.csr_op        = instr_i.r.funct3;
          ctrl_o.csr_addr      = instr_i.i.imm12;
          ctrl_o.csr_rs1_is_x0 = (instr_i.r.rs1 == '0);
          ctrl_o.we_rd         = (instr_i.r.rd != '0);
        end else if ((instr_i.r.funct3 == F3_PRIV) && (instr_i.r.rd == '0) &&
                     (instr_i.r.rs1 == '0)) begin
          if ((instr_i.r.funct7 == 7'h00) && (instr_i.r.rs2 == 5'd0)) begin
            ctrl_o.ecall = 1'b1;
          end else if ((instr_i.r.funct7 == 7'h00) && (instr_i.r.rs2 == 5'd1)) begin
            ctrl_o.ebreak = 1'b1;
          end else if ((instr_i.r.funct7 == F7_MRET) && (instr_i.r.rs2 == 5'd2)) begin
            ctrl_o.mret = 1'b1;
          end else if ((instr_i.r.funct7 == F7_WFI) && (instr_i.r.rs2 == 5'd5)) begin
            ctrl_o.wfi = 1'b1;
          end else begin
            illegal_o = 1'b1;
          end
        end else begin
          illegal_o = 1'b1;
        end
      end
      default: illegal_o = 1'b1;
    endcase

    if (illegal_o) begin
      ctrl_o = '0;
    end
  end

endmodule

`default_nettype wire

/* hw/register_file.sv */
// Integer register file
// 31 writable registers with x0 hardwired to zero, registered reads
`timescale 1ns/1ps
`default_nettype none

module register_file
  import rv_dec_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n_i,
  input  raddr_t rs1_addr_i,
  input  raddr_t rs2_addr_i,
  input  raddr_t rd_addr_i,
  input  rdata_t rd_data_i,
  input  logic   we_i,
  input  logic   re_i,
  output rdata_t rs1_data_o,
  output rdata_t rs2_data_o
);

  rdata_t regs [31:1];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
      rs1_data_o <= '0;
      rs2_data_o <= '0;
    end else begin
      if (we_i && (rd_addr_i != '0)) begin
        regs[rd_addr_i] <= rd_data_i;
      end
      // Same-cycle write is not bypassed
      if (re_i) begin
        rs1_data_o <= (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
        rs2_data_o <= (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];
      end
    end
  end

endmodule

`default_nettype wire

/* hw/decode.sv */
// Decode stage
// Decodes the fetched word, tracks its PC and registers the control word
// for execute. Squashes on jump and reports illegal instructions
`timescale 1ns/1ps
`default_nettype none

module decode
  import rv_dec_pkg::*;
#(
  parameter pc_t RESET_PC = '0
)(
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       jump_i,
  input  pc_t        pc_jump_i,
  input  logic       fetch_valid_i,
  output logic       fetch_ready_o,
  input  instr_raw_t fetch_instr_i,
  input  logic       wb_we_i,
  input  raddr_t     wb_rd_addr_i,
  input  rdata_t     wb_rd_data_i,
  output id_ex_t     id_ex_o,
  output rdata_t     rs1_data_o,
  output rdata_t     rs2_data_o,
  output logic       id_valid_o,
  input  logic       id_ready_i,
  output trap_t      trap_o
);

  instr_u instr;
  id_ex_t dec_ctrl;
  id_ex_t ctrl_d;
  id_ex_t ctrl_q;
  logic   illegal;
  logic   accept;
  logic   valid_q;
  logic   first_q;
  pc_t    pc_q;
  pc_t    pc_cur;

  assign instr         = fetch_instr_i;
  assign accept        = fetch_valid_i & id_ready_i & ~jump_i;
  assign fetch_ready_o = id_ready_i;
  assign id_valid_o    = valid_q;
  assign id_ex_o       = jump_i ? id_ex_t'('0) : ctrl_q;

  // PC of the word on the fetch side
  assign pc_cur = first_q ? pc_q + 32'd4 : pc_q;

  instr_decoder u_instr_decoder (
    .instr_i   (instr),
    .ctrl_o    (dec_ctrl),
    .illegal_o (illegal)
  );

  always_comb begin
    ctrl_d = dec_ctrl;
    if (!illegal) begin
      ctrl_d.pc_dec = pc_cur;
    end
  end

  always_comb begin
    trap_o = '0;
    if (accept && illegal) begin
      trap_o.active  = 1'b1;
      trap_o.pc_addr = pc_cur;
      trap_o.mtval   = fetch_instr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      ctrl_q  <= '0;
      pc_q    <= RESET_PC;
      first_q <= 1'b0;
    end else if (jump_i) begin
      // Younger instruction is on the wrong path
      valid_q <= 1'b0;
      ctrl_q  <= '0;
      pc_q    <= pc_jump_i;
      first_q <= 1'b0;
    end else if (id_ready_i) begin
      valid_q <= fetch_valid_i;
      ctrl_q  <= accept ? ctrl_d : id_ex_t'('0);
      if (accept) begin
        pc_q    <= pc_cur;
        first_q <= 1'b1;
      end
    end
  end

  register_file u_register_file (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rs1_addr_i (instr.r.rs1),
    .rs2_addr_i (instr.r.rs2),
    .rd_addr_i  (wb_rd_addr_i),
    .rd_data_i  (wb_rd_data_i),
    .we_i       (wb_we_i),
    .re_i       (id_ready_i),
    .rs1_data_o (rs1_data_o),
    .rs2_data_o (rs2_data_o)
  );

endmodule

`default_nettype wire

/* hw/decode_unit.sv */
// Decode unit top level
// RV32I decode stage with its register file, reset PC fixed here
`timescale 1ns/1ps
`default_nettype none

module decode_unit
  import rv_dec_pkg::*;
#(
  parameter pc_t RESET_PC = 32'h0000_1000
)(
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       jump_i,
  input  pc_t        pc_jump_i,
  input  logic       fetch_valid_i,
  output logic       fetch_ready_o,
  input  instr_raw_t fetch_instr_i,
  input  logic       wb_we_i,
  input  raddr_t     wb_rd_addr_i,
  input  rdata_t     wb_rd_data_i,
  output id_ex_t     id_ex_o,
  output rdata_t     rs1_data_o,
  output rdata_t     rs2_data_o,
  output logic       id_valid_o,
  input  logic       id_ready_i,
  output trap_t      trap_o
);

  decode #(
    .RESET_PC (RESET_PC)
  ) u_decode (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .jump_i        (jump_i),
    .pc_jump_i     (pc_jump_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .fetch_instr_i (fetch_instr_i),
    .wb_we_i       (wb_we_i),
    .wb_rd_addr_i  (wb_rd_addr_i),
    .wb_rd_data_i  (wb_rd_data_i),
    .id_ex_o       (id_ex_o),
    .rs1_data_o    (rs1_data_o),
    .rs2_data_o    (rs2_data_o),
    .id_valid_o    (id_valid_o),
    .id_ready_i    (id_ready_i),
    .trap_o        (trap_o)
  );

endmodule

`default_nettype wire

/* tests/tb_decode_unit.sv */
// Testbench for the decode unit
// Preloads the register file, runs a table of fetch cycles through the
// DUT and compares control word, read data, valid and trap with the table
`timescale 1ns/1ps
`default_nettype none

module tb_decode_unit
  import rv_dec_pkg::*;
;

  typedef struct {
    string      name;
    instr_raw_t instr;
    logic       valid;
    logic       ready;
    logic       jump;
    pc_t        pc_jump;
    id_ex_t     ctrl;
    logic       out_valid;
    rdata_t     rs1;
    rdata_t     rs2;
    trap_t      trap;
  } row_t;

  logic       clk;
  logic       rst_n_i;
  logic       jump_i;
  pc_t        pc_jump_i;
  logic       fetch_valid_i;
  logic       fetch_ready_o;
  instr_raw_t fetch_instr_i;
  logic       wb_we_i;
  raddr_t     wb_rd_addr_i;
  rdata_t     wb_rd_data_i;
  id_ex_t     id_ex_o;
  rdata_t     rs1_data_o;
  rdata_t     rs2_data_o;
  logic       id_valid_o;
  logic       id_ready_i;
  trap_t      trap_o;

  row_t   rows[$];
  int     errors       = 0;
  int     tests        = 0;
  int     failed_tests = 0;
  int     cycles       = 0;
  int     max_cycles   = 16 + 40 + 50;
  int     seed         = 32'h14ba_379a;

  // Expected state of the stage as the table is built
  pc_t    m_next_pc = 32'h0000_1000;
  id_ex_t m_ctrl    = '0;
  logic   m_valid   = 1'b0;
  rdata_t m_rs1     = '0;
  rdata_t m_rs2     = '0;

  decode_unit DUT (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .jump_i        (jump_i),
    .pc_jump_i     (pc_jump_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .fetch_instr_i (fetch_instr_i),
    .wb_we_i       (wb_we_i),
    .wb_rd_addr_i  (wb_rd_addr_i),
    .wb_rd_data_i  (wb_rd_data_i),
    .id_ex_o       (id_ex_o),
    .rs1_data_o    (rs1_data_o),
    .rs2_data_o    (rs2_data_o),
    .id_valid_o    (id_valid_o),
    .id_ready_i    (id_ready_i),
    .trap_o        (trap_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Preloaded register contents with x0 reading zero
  function automatic rdata_t reg_value(input raddr_t idx);
    return (idx == 5'd0) ? 32'd0 : 32'h100 + {27'd0, idx};
  endfunction

  function automatic id_ex_t ctrl_word(input raddr_t rd, input raddr_t rs1, input raddr_t rs2,
                                       input logic [2:0] f3, input op_sel_t a, input op_sel_t b,
                                       input rdata_t imm, input logic we);
    id_ex_t c;
    c          = '0;
    c.rd_addr  = rd;
    c.rs1_addr = rs1;
    c.rs2_addr = rs2;
    c.funct3   = f3;
    c.rs1_op   = a;
    c.rs2_op   = b;
    c.imm      = imm;
    c.we_rd    = we;
    return c;
  endfunction

  task automatic check_ctrl(input string name, input id_ex_t act, input id_ex_t exp);
    if (act !== exp) begin
      errors++;
      $display("Error at %0t: %s = %h, expected %h", $realtime, name, act, exp);
    end
  endtask

  task automatic check_data(input string name, input rdata_t act, input rdata_t exp);
    if (act !== exp) begin
      errors++;
      $display("Error at %0t: %s = %h, expected %h", $realtime, name, act, exp);
    end
  endtask

  task automatic check_trap(input string name, input trap_t act, input trap_t exp);
    if (act !== exp) begin
      errors++;
      $display("Error at %0t: %s = %h, expected %h", $realtime, name, act, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      errors++;
      $display("Error at %0t: %s = %b, expected %b", $realtime, name, act, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    if (errors != errs_before) begin
      failed_tests++;
      $display("test %-12s fail (%0d errors)", name, errors - errs_before);
    end else begin
      $display("test %-12s pass", name);
    end
  endtask

  // Adds one fetch cycle and works out what the stage shows one cycle later
  task automatic add_row(input string name, input instr_raw_t w, input logic v, input logic r,
                         input logic j, input pc_t pj, input id_ex_t c, input logic ill);
    row_t row;
    row.name    = name;
    row.instr   = w;
    row.valid   = v;
    row.ready   = r;
    row.jump    = j;
    row.pc_jump = pj;
    row.trap    = '0;
    if (j) begin
      m_ctrl    = '0;
      m_valid   = 1'b0;
      m_next_pc = pj;
    end else if (r && v) begin
      if (ill) begin
        m_ctrl             = '0;
        row.trap.active    = 1'b1;
        row.trap.pc_addr   = m_next_pc;
        row.trap.mtval     = w;
      end else begin
        m_ctrl        = c;
        m_ctrl.pc_dec = m_next_pc;
      end
      m_valid   = 1'b1;
      m_next_pc = m_next_pc + 32'd4;
    end else if (r) begin
      m_ctrl  = '0;
      m_valid = 1'b0;
    end
    if (r) begin
      m_rs1 = reg_value(w[19:15]);
      m_rs2 = reg_value(w[24:20]);
    end
    row.ctrl      = m_ctrl;
    row.out_valid = m_valid;
    row.rs1       = m_rs1;
    row.rs2       = m_rs2;
    rows.push_back(row);
    max_cycles += 4;
  endtask

  task automatic build_table();
    id_ex_t c;
    c = ctrl_word(5'd1, 5'd2, 5'd5, 3'd0, REG_RF, IMM, 32'd5, 1'b1);
    add_row("ADDI", 32'h0051_0093, 1'b1, 1'b1, 1'b0, '0, c, 1'b0);
    c = ctrl_word(5'd3, 5'd4, 5'd7, 3'd5, REG_RF, IMM, 32'h0000_0407, 1'b1);
    c.alt = 1'b1;
    add_row("SRAI", 32'h4072_5193, 1'b1, 1'b1, 1'b0, '0, c, 1'b0);
    c = ctrl_word(5'd5, 5'd8, 5'd3, 3'd0, ZERO, IMM, 32'h1234_5000, 1'b1);
    add_row("LUI", 32'h1234_52B7, 1'b1, 1'b1, 1'b0, '0, c, 1'b0);
    add_row("idle", 32'h0000_0000, 1'b0, 1'b1, 1'b0, '0, '0, 1'b0);
    c = ctrl_word(5'd6, 5'd2, 5'd0, 3'd0, PC, IMM, 32'h0001_0000, 1'b1);
    add_row("AUIPC", 32'h0001_0317, 1'b1, 1'b1, 1'b0, '0, c, 1'b0);
    c = ctrl_word(5'd7, 5'd8, 5'd9, 3'd0, REG_RF, REG_RF, 32'd0, 1'b1);
    c.alt = 1'b1;
    add_row("SUB", 32'h4094_03B3, 1'b1, 1'b1, 1'b0, '0, c, 1'b0);
    // Word under the jump is dropped, then refetched at the target
    add_row("jump", 32'h0100_00EF, 1'b1, 1'b1, 1'b1, 32'h0000_2000, '0, 1'b0);
    c = ctrl_word(5'd1, 5'd0, 5'd16, 3'd0, PC, IMM, 32'd16, 1'b1);
    c.jump = 1'b1;
    add_row("JAL", 32'h0100_00EF, 1'b1, 1'b1, 1'b0, '0, c, 1'b0);
    c = ctrl_word(5'd0, 5'd1, 5'd4, 3'd0, REG_RF, IMM, 32'd4, 1'b1);
    c.jump = 1'b1;
    add_row("JALR", 32'h0040_8067, 1'b1, 1'b1, 1'b0, '0, c, 1'b0);
    c = ctrl_word(5'd25, 5'd1, 5'd2, 3'd0, REG_RF, REG_RF, 32'hFFFF_FFF8, 1'b0);
    c.branch = 1'b1;
    add_row("BEQ", 32'hFE20_8CE3, 1'b1, 1'b1, 1'b0, '0, c, 1'b0);
    c = ctrl_word(5'd10, 5'd2, 5'd8, 3'd0, REG_RF, IMM, 32'd8, 1'b1);
    c.lsu   = LSU_LOAD;
    c.lsu_w = 3'd2;
    add_row("LW", 32'h0081_2503, 1'b1, 1'b1, 1'b0, '0, c, 1'b0);
    c = ctrl_word(5'd28, 5'd2, 5'd3, 3'd0, REG_RF, IMM, 32'hFFFF_FFFC, 1'b0);
    c.lsu = LSU_STORE;
    for (int k = 0; k < 3; k++) begin
      add_row("stall", 32'hFE31_0E23, 1'b1, 1'b0, 1'b0, '0, c, 1'b0);
    end
    add_row("SB", 32'hFE31_0E23, 1'b1, 1'b1, 1'b0, '0, c, 1'b0);
    c = ctrl_word(5'd0, 5'd0, 5'd31, 3'd0, ZERO, ZERO, 32'd0, 1'b0);
    add_row("FENCE", 32'h0FF0_000F, 1'b1, 1'b1, 1'b0, '0, c, 1'b0);
    add_row("illegal_op", 32'h1234_567B, 1'b1, 1'b1, 1'b0, '0, '0, 1'b1);
    // CSRRW from x0
    c = ctrl_word(5'd5, 5'd0, 5'd0, 3'd0, REG_RF, ZERO, 32'd0, 1'b1);
    c.csr_op        = 3'd1;
    c.csr_addr      = 12'h300;
    c.csr_rs1_is_x0 = 1'b1;
    add_row("CSRRW", 32'h3000_12F3, 1'b1, 1'b1, 1'b0, '0, c, 1'b0);
    c = ctrl_word(5'd0, 5'd3, 5'd4, 3'd0, IMM, ZERO, 32'd3, 1'b0);
    c.csr_op   = 3'd6;
    c.csr_addr = 12'h304;
    add_row("CSRRSI", 32'h3041_E073, 1'b1, 1'b1, 1'b0, '0, c, 1'b0);
    add_row("illegal_sys", 32'h0000_4073, 1'b1, 1'b1, 1'b0, '0, '0, 1'b1);
    c = ctrl_word(5'd0, 5'd0, 5'd0, 3'd0, ZERO, ZERO, 32'd0, 1'b0);
    c.ecall = 1'b1;
    add_row("ECALL", 32'h0000_0073, 1'b1, 1'b1, 1'b0, '0, c, 1'b0);
    c = ctrl_word(5'd0, 5'd0, 5'd1, 3'd0, ZERO, ZERO, 32'd0, 1'b0);
    c.ebreak = 1'b1;
    add_row("EBREAK", 32'h0010_0073, 1'b1, 1'b1, 1'b0, '0, c, 1'b0);
    c = ctrl_word(5'd0, 5'd0, 5'd2, 3'd0, ZERO, ZERO, 32'd0, 1'b0);
    c.mret = 1'b1;
    add_row("MRET", 32'h3020_0073, 1'b1, 1'b1, 1'b0, '0, c, 1'b0);
    c = ctrl_word(5'd0, 5'd0, 5'd5, 3'd0, ZERO, ZERO, 32'd0, 1'b0);
    c.wfi = 1'b1;
    add_row("WFI", 32'h1050_0073, 1'b1, 1'b1, 1'b0, '0, c, 1'b0);
    add_row("idle_end", 32'h0000_0000, 1'b0, 1'b1, 1'b0, '0, '0, 1'b0);
  endtask

  initial begin : watchdog
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the test sequence did not complete", max_cycles);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : main
    int      errs_before;
    raddr_t  idx;
    rdata_t  rnd;
    rdata_t  rnd_word;
    rst_n_i       = 1'b0;
    jump_i        = 1'b0;
    pc_jump_i     = '0;
    fetch_valid_i = 1'b0;
    fetch_instr_i = '0;
    wb_we_i       = 1'b0;
    wb_rd_addr_i  = '0;
    wb_rd_data_i  = '0;
    id_ready_i    = 1'b0;
    build_table();

    repeat (16) @(posedge clk);
    #1;
    rst_n_i = 1'b1;

    errs_before = errors;
    check_bit("id_valid_o", id_valid_o, 1'b0);
    check_bit("trap_o.active", trap_o.active, 1'b0);
    check_ctrl("id_ex_o", id_ex_o, '0);
    check_bit("fetch_ready_o", fetch_ready_o, 1'b0);
    id_ready_i = 1'b1;
    #1;
    check_bit("fetch_ready_o", fetch_ready_o, 1'b1);
    report_test("reset", errs_before);

    for (int n = 1; n < 32; n++) begin
      @(posedge clk);
      #1;
      wb_we_i      = 1'b1;
      wb_rd_addr_i = raddr_t'(n);
      wb_rd_data_i = 32'h100 + n;
    end
    @(posedge clk);
    #1;
    wb_we_i = 1'b0;

    for (int i = 0; i < rows.size(); i++) begin
      errs_before   = errors;
      fetch_instr_i = rows[i].instr;
      fetch_valid_i = rows[i].valid;
      id_ready_i    = rows[i].ready;
      jump_i        = rows[i].jump;
      pc_jump_i     = rows[i].pc_jump;
      #4;
      // Combinational outputs within the fetch cycle
      check_trap("trap_o", trap_o, rows[i].trap);
      check_bit("fetch_ready_o", fetch_ready_o, rows[i].ready);
      if (rows[i].jump) begin
        check_ctrl("id_ex_o during jump", id_ex_o, '0);
      end
      @(posedge clk);
      #1;
      check_ctrl("id_ex_o", id_ex_o, rows[i].ctrl);
      check_data("rs1_data_o", rs1_data_o, rows[i].rs1);
      check_data("rs2_data_o", rs2_data_o, rows[i].rs2);
      check_bit("id_valid_o", id_valid_o, rows[i].out_valid);
      report_test(rows[i].name, errs_before);
    end

    // Random write-back read in the same cycle and the next
    errs_before   = errors;
    fetch_valid_i = 1'b0;
    jump_i        = 1'b0;
    id_ready_i    = 1'b1;
    rnd_word      = $random(seed);
    idx           = rnd_word[4:0];
    if (idx == 5'd0) begin
      idx = 5'd1;
    end
    rnd           = $random(seed);
    wb_we_i       = 1'b1;
    wb_rd_addr_i  = idx;
    wb_rd_data_i  = rnd;
    fetch_instr_i = {12'h000, idx, 3'b000, 5'd0, 7'b0110011};
    @(posedge clk);
    #1;
    check_data("rs1_data_o", rs1_data_o, reg_value(idx));
    check_data("rs2_data_o", rs2_data_o, 32'd0);
    wb_we_i = 1'b0;
    @(posedge clk);
    #1;
    check_data("rs1_data_o", rs1_data_o, rnd);
    report_test("wb_random", errs_before);

    $display("Summary: %0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* decode_unit.f */
hw/rv_dec_pkg.sv
hw/imm_gen.sv
hw/instr_decoder.sv
hw/register_file.sv
hw/decode.sv
hw/decode_unit.sv
tests/tb_decode_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the decode unit testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -f decode_unit.f --top-module tb_decode_unit -o tb_decode_unit

./obj_dir/tb_decode_unit > "$LOG"
cat "$LOG"

if grep -qF "*** FAILED ***" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
